// File: verilog.f
fp16_pkg.sv
fdiv_pkg.sv
fdiv_unpack.sv
fdiv_recur.sv
fdiv_round.sv
fdiv_top.sv
tb_fdiv_sva.sv
tb_fdiv.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_fdiv -f verilog.f -Mdir obj_dir -o sim_fdiv
./obj_dir/sim_fdiv > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

// File: tb_fdiv.sv
`timescale 1ns/1ns

module tb_fdiv
    import fp16_pkg::*, fdiv_pkg::*;
();

    localparam int MAX_CYCLES = 12000;
    localparam int LATENCY    = QUOT_BITS + 1;
    localparam int STREAM_OPS = 150;

    logic        clk;
    logic        resetn;
    logic        req_valid;
    logic        req_ready;
    fp16_t       op_a;
    fp16_t       op_b;
    round_mode_t round_mode;
    logic        resp_valid;
    logic        resp_ready;
    fp16_t       result;
    flags_t      flags;

    int     n_checks = 0;
    int     n_errors = 0;
    int     cycles   = 0;
    integer seed     = 32'h9bd6;

    fdiv_top i_fdiv_top (
         .clk        (clk        )
        ,.resetn     (resetn     )
        ,.req_valid  (req_valid  )
        ,.req_ready  (req_ready  )
        ,.op_a       (op_a       )
        ,.op_b       (op_b       )
        ,.round_mode (round_mode )
        ,.resp_valid (resp_valid )
        ,.resp_ready (resp_ready )
        ,.result     (result     )
        ,.flags      (flags      )
    );

    always #5 clk = ~clk;

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run was stopped after %0d cycles", cycles);
        $display("TEST FAIL");
        $finish;
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // significand with hidden bit in [1024, 2047] and its unbiased exponent
    task automatic normalize_op(input fp16_t x, output int m, output int e);
        m = int'(x[FRAC_W-1:0]);
        if (x[14:10] == 5'd0) begin
            e = 1 - EXP_BIAS;
            while (m < (1 << FRAC_W)) begin
                m = m << 1;
                e = e - 1;
            end
        end else begin
            m = m + (1 << FRAC_W);
            e = int'(x[14:10]) - EXP_BIAS;
        end
    endtask

    task automatic expected_div(input fp16_t a, input fp16_t b, input round_mode_t mode,
                                output fp16_t res, output flags_t flg);
        logic a_nan, b_nan, a_snan, b_snan, a_inf, b_inf, a_zero, b_zero, sgn;
        int   ma, mb, ea, eb, e, q, rem, kept, rbit, sbit, up;
        a_nan  = (&a[14:10]) && (a[9:0] != 10'd0);
        b_nan  = (&b[14:10]) && (b[9:0] != 10'd0);
        a_snan = a_nan && !a[9];
        b_snan = b_nan && !b[9];
        a_inf  = (&a[14:10]) && (a[9:0] == 10'd0);
        b_inf  = (&b[14:10]) && (b[9:0] == 10'd0);
        a_zero = (a[14:0] == 15'd0);
        b_zero = (b[14:0] == 15'd0);
        sgn    = a[15] ^ b[15];
        flg    = '0;
        res    = '0;
        if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
            res = FP16_QNAN;
            flg[FLAG_NV] = a_snan | b_snan | (a_zero & b_zero) | (a_inf & b_inf);
        end else if (a_inf) begin
            res = {sgn, FP16_INF_MAG};
        end else if (b_zero) begin
            res = {sgn, FP16_INF_MAG};
            flg[FLAG_DZ] = 1'b1;
        end else if (a_zero || b_inf) begin
            res = {sgn, 15'd0};
        end else begin
            normalize_op(a, ma, ea);
            normalize_op(b, mb, eb);
            // long division leaves 13 fraction bits and a remainder
            q   = (ma << (QUOT_BITS - 1)) / mb;
            rem = (ma << (QUOT_BITS - 1)) % mb;
            e   = ea - eb + EXP_BIAS;
            if (q < (1 << (QUOT_BITS - 1))) begin
                q = q << 1;
                e = e - 1;
            end
            kept = q >> 3;
            rbit = (q >> 2) & 1;
            sbit = ((q & 3) != 0 || rem != 0) ? 1 : 0;
            up   = (mode != ROUND_RTZ && rbit == 1 && (sbit == 1 || (kept & 1) == 1)) ? 1 : 0;
            kept = kept + up;
            if (kept == (2 << FRAC_W)) begin
                kept = 1 << FRAC_W;
                e = e + 1;
            end
            if (e > EXP_MAX_NORM) begin
                res = {sgn, (mode == ROUND_RTZ) ? FP16_MAX_MAG : FP16_INF_MAG};
                flg[FLAG_OF] = 1'b1;
                flg[FLAG_NX] = 1'b1;
            end else if (e < 1) begin
                res = {sgn, 15'd0};
                flg[FLAG_UF] = 1'b1;
                flg[FLAG_NX] = 1'b1;
            end else begin
                res = {sgn, e[4:0], kept[9:0]};
                flg[FLAG_NX] = (rbit != 0) || (sbit != 0);
            end
        end
    endtask

    // ----------------------------------------
    // drive and check
    // ----------------------------------------
    task automatic check_response(input string name, input fp16_t exp_res, input flags_t exp_flg);
        n_checks++;
        assert (result === exp_res) else begin
            $display("ERR %s result expected %h actual %h", name, exp_res, result);
            n_errors++;
        end
        n_checks++;
        assert (flags === exp_flg) else begin
            $display("ERR %s flags expected %b actual %b", name, exp_flg, flags);
            n_errors++;
        end
    endtask

    task automatic divide_and_check(input string name, input fp16_t a, input fp16_t b,
                                    input round_mode_t mode);
        fp16_t  exp_res;
        flags_t exp_flg;
        int     lat;
        expected_div(a, b, mode, exp_res, exp_flg);
        @(negedge clk);
        req_valid  = 1'b1;
        op_a       = a;
        op_b       = b;
        round_mode = mode;
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        lat = 0;
        @(negedge clk);
        req_valid = 1'b0;
        while (!resp_valid) begin
            @(negedge clk);
            lat++;
        end
        n_checks++;
        assert (lat == LATENCY) else begin
            $display("ERR %s latency expected %0d actual %0d", name, LATENCY, lat);
            n_errors++;
        end
        check_response(name, exp_res, exp_flg);
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic exact_quotients();
        divide_and_check("6/2", 16'h4600, 16'h4000, 3'b000);
        divide_and_check("1/4", 16'h3c00, 16'h4400, 3'b000);
        divide_and_check("-3/1.5", 16'hc200, 16'h3e00, ROUND_RTZ);
    endtask

    task automatic inexact_rounding();
        divide_and_check("1/3 rne", 16'h3c00, 16'h4200, 3'b000);
        divide_and_check("1/3 rtz", 16'h3c00, 16'h4200, ROUND_RTZ);
        divide_and_check("2/3 rne", 16'h4000, 16'h4200, 3'b000);
        divide_and_check("2/3 rtz", 16'h4000, 16'h4200, ROUND_RTZ);
        // 1+ulp over 3 has its round bit set, so the two modes differ
        divide_and_check("(1+ulp)/3 rne", 16'h3c01, 16'h4200, 3'b000);
        divide_and_check("(1+ulp)/3 rtz", 16'h3c01, 16'h4200, ROUND_RTZ);
        // codes other than rtz all round to nearest even
        divide_and_check("(1+ulp)/3 code 110", 16'h3c01, 16'h4200, 3'b110);
        divide_and_check("-2/3 rtz", 16'hc000, 16'h4200, ROUND_RTZ);
    endtask

    task automatic special_operands();
        divide_and_check("qnan/1", 16'h7e00, 16'h3c00, 3'b000);
        divide_and_check("snan/1", 16'h7d00, 16'h3c00, 3'b000);
        divide_and_check("1/snan", 16'h3c00, 16'hfc01, 3'b000);
        divide_and_check("0/-0", 16'h0000, 16'h8000, 3'b000);
        divide_and_check("inf/-inf", 16'h7c00, 16'hfc00, 3'b000);
        divide_and_check("1/0", 16'h3c00, 16'h0000, 3'b000);
        divide_and_check("-1/0", 16'hbc00, 16'h0000, 3'b000);
        divide_and_check("inf/2", 16'h7c00, 16'h4000, 3'b000);
        divide_and_check("-inf/0", 16'hfc00, 16'h0000, 3'b000);
        divide_and_check("0/3", 16'h0000, 16'h4200, 3'b000);
        divide_and_check("-0/3", 16'h8000, 16'h4200, 3'b000);
        divide_and_check("5/-inf", 16'h4500, 16'hfc00, 3'b000);
    endtask

    task automatic range_limits();
        divide_and_check("max/min rne", 16'h7bff, 16'h0400, 3'b000);
        divide_and_check("max/min rtz", 16'h7bff, 16'h0400, ROUND_RTZ);
        divide_and_check("-max/min rtz", 16'hfbff, 16'h0400, ROUND_RTZ);
        divide_and_check("min/max", 16'h0400, 16'h7bff, 3'b000);
        divide_and_check("-min/big", 16'h8400, 16'h7800, 3'b000);
    endtask

    task automatic subnormal_operands();
        divide_and_check("sub/min", 16'h0001, 16'h0400, 3'b000);
        divide_and_check("sub/sub", 16'h03ff, 16'h0200, 3'b000);
        divide_and_check("third/sub", 16'h3555, 16'h02ab, 3'b000);
        divide_and_check("sub/tiny sub", 16'h0300, 16'h0010, ROUND_RTZ);
        divide_and_check("2/sub", 16'h4000, 16'h0155, 3'b000);
    endtask

    function automatic fp16_t random_normal();
        integer bits;
        fp16_t  v;
        bits = $random(seed);
        v = bits[15:0];
        if (v[14:10] == 5'd0 || v[14:10] == 5'd31) begin
            v[14:10] = 5'd15;
        end
        return v;
    endfunction

    // operands are drawn up front so the ready pattern does not shift them
    task automatic random_stream();
        fp16_t       ops_a[$];
        fp16_t       ops_b[$];
        round_mode_t modes[$];
        fp16_t       res_q[$];
        flags_t      flg_q[$];
        fp16_t       r;
        flags_t      f;
        int          seen;
        string       name;
        for (int i = 0; i < STREAM_OPS; i++) begin
            ops_a.push_back(random_normal());
            ops_b.push_back(random_normal());
            modes.push_back(round_mode_t'($random(seed)));
        end
        seen = 0;
        fork
            begin
                for (int i = 0; i < STREAM_OPS; i++) begin
                    @(negedge clk);
                    req_valid  = 1'b1;
                    op_a       = ops_a[i];
                    op_b       = ops_b[i];
                    round_mode = modes[i];
                    while (!req_ready) @(negedge clk);
                    @(posedge clk);
                    // the operation is pending from its accepting edge on
                    expected_div(ops_a[i], ops_b[i], modes[i], r, f);
                    res_q.push_back(r);
                    flg_q.push_back(f);
                end
                @(negedge clk);
                req_valid = 1'b0;
            end
            begin
                while (seen < STREAM_OPS) begin
                    @(negedge clk);
                    resp_ready = $random(seed) & 1;
                    if (resp_valid && resp_ready) begin
                        name = $sformatf("stream op %0d", seen);
                        n_checks++;
                        assert (res_q.size() > 0) else begin
                            $display("a response arrived with no operation pending");
                            n_errors++;
                        end
                        if (res_q.size() > 0) begin
                            check_response(name, res_q.pop_front(), flg_q.pop_front());
                        end
                        seen++;
                    end
                end
            end
        join
        @(negedge clk);
        resp_ready = 1'b1;
        n_checks++;
        assert (!resp_valid && res_q.size() == 0) else begin
            $display("the stream left an extra response or an unanswered operation");
            n_errors++;
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        req_valid  = 1'b0;
        op_a       = '0;
        op_b       = '0;
        round_mode = '0;
        resp_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        n_checks++;
        assert (req_ready && !resp_valid) else begin
            $display("after reset req_ready is not high or resp_valid is not low");
            n_errors++;
        end
        exact_quotients();
        inexact_rounding();
        special_operands();
        range_limits();
        subnormal_operands();
        random_stream();
        $display("checks %0d errors %0d assertion failures %0d", n_checks, n_errors,
                 i_fdiv_top.i_handshake_sva.n_fail);
        if (n_errors == 0 && i_fdiv_top.i_handshake_sva.n_fail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb_fdiv_sva.sv
`timescale 1ns/1ns

module fdiv_handshake_sva
    import fp16_pkg::*, fdiv_pkg::*;
(
     input logic   clk
    ,input logic   resetn
    ,input logic   req_valid
    ,input logic   req_ready
    ,input logic   done_valid
    ,input logic   done_ready
    ,input logic   resp_valid
    ,input logic   resp_ready
    ,input fp16_t  result
    ,input flags_t flags
);

    // count of failed assertions
    int n_fail = 0;

    // an accepted operation sits in the recurrence until the round stage takes it
    logic in_recur;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            in_recur <= 1'b0;
        end else if (req_valid && req_ready) begin
            in_recur <= 1'b1;
        end else if (done_valid && done_ready) begin
            in_recur <= 1'b0;
        end
    end

    held_resp: assert property (@(posedge clk) disable iff (!resetn)
        resp_valid && !resp_ready |=> resp_valid && $stable(result) && $stable(flags))
        else begin
            $error("resp_valid or its data changed while resp_ready was low");
            n_fail++;
        end

    no_resp_in_reset: assert property (@(posedge clk) !resetn |-> !resp_valid)
        else begin
            $error("resp_valid high during reset");
            n_fail++;
        end

    busy_not_ready: assert property (@(posedge clk) disable iff (!resetn)
        in_recur |-> !req_ready)
        else begin
            $error("req_ready high while an operation is in the recurrence");
            n_fail++;
        end

endmodule

bind fdiv_top fdiv_handshake_sva i_handshake_sva (
     .clk        (clk        )
    ,.resetn     (resetn     )
    ,.req_valid  (req_valid  )
    ,.req_ready  (req_ready  )
    ,.done_valid (done_valid )
    ,.done_ready (done_ready )
    ,.resp_valid (resp_valid )
    ,.resp_ready (resp_ready )
    ,.result     (result     )
    ,.flags      (flags      )
);

// File: fdiv_top.sv
`timescale 1ns/1ns

module fdiv_top
    import fp16_pkg::*, fdiv_pkg::*;
(
     input  logic        clk
    ,input  logic        resetn
    ,input  logic        req_valid
    ,output logic        req_ready
    ,input  fp16_t       op_a
    ,input  fp16_t       op_b
    ,input  round_mode_t round_mode
    ,output logic        resp_valid
    ,input  logic        resp_ready
    ,output fp16_t       result
    ,output flags_t      flags
);

    // unpack to recurrence
    mant_t       mant_a;
    mant_t       mant_b;
    sexp_t       exp_diff;
    logic        sign;
    special_t    special;
    logic        nv;
    logic        dz;

    // recurrence to round
    logic        done_valid;
    logic        done_ready;
    quot_t       quot;
    logic        sticky;
    sexp_t       d_exp;
    logic        d_sign;
    special_t    d_special;
    logic        d_nv;
    logic        d_dz;
    round_mode_t d_round_mode;

    fdiv_unpack u_unpack (
         .op_a     (op_a     )
        ,.op_b     (op_b     )
        ,.mant_a   (mant_a   )
        ,.mant_b   (mant_b   )
        ,.exp_diff (exp_diff )
        ,.sign     (sign     )
        ,.special  (special  )
        ,.nv       (nv       )
        ,.dz       (dz       )
    );

    fdiv_recur u_recur (
         .clk          (clk          )
        ,.resetn       (resetn       )
        ,.req_valid    (req_valid    )
        ,.req_ready    (req_ready    )
        ,.mant_a       (mant_a       )
        ,.mant_b       (mant_b       )
        ,.exp_diff     (exp_diff     )
        ,.sign         (sign         )
        ,.special      (special      )
        ,.nv           (nv           )
        ,.dz           (dz           )
        ,.round_mode   (round_mode   )
        ,.done_valid   (done_valid   )
        ,.done_ready   (done_ready   )
        ,.quot         (quot         )
        ,.sticky       (sticky       )
        ,.d_exp        (d_exp        )
        ,.d_sign       (d_sign       )
        ,.d_special    (d_special    )
        ,.d_nv         (d_nv         )
        ,.d_dz         (d_dz         )
        ,.d_round_mode (d_round_mode )
    );

    fdiv_round u_round (
         .clk          (clk          )
        ,.resetn       (resetn       )
        ,.done_valid   (done_valid   )
        ,.done_ready   (done_ready   )
        ,.quot         (quot         )
        ,.sticky       (sticky       )
        ,.d_exp        (d_exp        )
        ,.d_sign       (d_sign       )
        ,.d_special    (d_special    )
        ,.d_nv         (d_nv         )
        ,.d_dz         (d_dz         )
        ,.d_round_mode (d_round_mode )
        ,.resp_valid   (resp_valid   )
        ,.resp_ready   (resp_ready   )
        ,.result       (result       )
        ,.flags        (flags        )
    );

endmodule

// File: fdiv_round.sv
`timescale 1ns/1ns

module fdiv_round
    import fp16_pkg::*, fdiv_pkg::*;
(
     input  logic        clk
    ,input  logic        resetn
    ,input  logic        done_valid
    ,output logic        done_ready
    ,input  quot_t       quot
    ,input  logic        sticky
    ,input  sexp_t       d_exp
    ,input  logic        d_sign
    ,input  special_t    d_special
    ,input  logic        d_nv
    ,input  logic        d_dz
    ,input  round_mode_t d_round_mode
    ,output logic        resp_valid
    ,input  logic        resp_ready
    ,output fp16_t       result
    ,output flags_t      flags
);

    logic              norm_shift;
    quot_t             q_norm;
    sexp_t             exp_pre;
    mant_t             kept;
    logic              round_bit;
    logic              sticky_bit;
    logic              rtz;
    logic              round_up;
    logic [FRAC_W+1:0] mant_rnd;
    logic              carry;
    sexp_t             exp_rnd;
    fp16_t             res_d;
    flags_t            flags_d;
    logic              load;

    // ----------------------------------------
    // normalize
    // ----------------------------------------
    // quotient below one loses its top bit and one from the exponent
    assign norm_shift = ~quot[QUOT_BITS-1];
    assign q_norm     = norm_shift ? {quot[QUOT_BITS-2:0], 1'b0} : quot;
    assign exp_pre    = d_exp + sexp_t'(EXP_BIAS) - sexp_t'(norm_shift);

    assign kept       = q_norm[QUOT_BITS-1 -: FRAC_W+1];
    assign round_bit  = q_norm[ROUND_POS];
    assign sticky_bit = (|q_norm[ROUND_POS-1:0]) | sticky;

    // ----------------------------------------
    // round
    // ----------------------------------------
    assign rtz      = (d_round_mode == ROUND_RTZ);
    assign round_up = ~rtz & round_bit & (sticky_bit | kept[0]);
    assign mant_rnd = {1'b0, kept} + {{(FRAC_W+1){1'b0}}, round_up};

    // carry out leaves 1.000, so only the exponent moves
    assign carry    = mant_rnd[FRAC_W+1];
    assign exp_rnd  = exp_pre + sexp_t'(carry);

    // ----------------------------------------
    // range check and packing
    // ----------------------------------------
    always_comb begin
        res_d   = '0;
        flags_d = '0;
        flags_d[FLAG_NV] = d_nv;
        flags_d[FLAG_DZ] = d_dz;
        case (d_special)
            SPECIAL_QNAN: res_d = FP16_QNAN;
            SPECIAL_INF:  res_d = {d_sign, FP16_INF_MAG};
            SPECIAL_ZERO: res_d = {d_sign, {(EXP_W+FRAC_W){1'b0}}};
            default: begin
                if (exp_rnd > EXP_MAX_NORM) begin
                    res_d = {d_sign, rtz ? FP16_MAX_MAG : FP16_INF_MAG};
                    flags_d[FLAG_OF] = 1'b1;
                    flags_d[FLAG_NX] = 1'b1;
                end else if (exp_rnd < 1) begin
                    // no subnormal results, flush to signed zero
                    res_d = {d_sign, {(EXP_W+FRAC_W){1'b0}}};
                    flags_d[FLAG_UF] = 1'b1;
                    flags_d[FLAG_NX] = 1'b1;
                end else begin
                    res_d = {d_sign, exp_rnd[EXP_W-1:0], mant_rnd[FRAC_W-1:0]};
                    flags_d[FLAG_NX] = round_bit | sticky_bit;
                end
            end
        endcase
    end

    // ----------------------------------------
    // output register
    // ----------------------------------------
    assign done_ready = ~resp_valid | resp_ready;
    assign load       = done_valid & done_ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            resp_valid <= 1'b0;
        end else if (load) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            result <= res_d;
            flags  <= flags_d;
        end
    end

endmodule

// File: fdiv_recur.sv
`timescale 1ns/1ns

module fdiv_recur
    import fp16_pkg::*, fdiv_pkg::*;
(
     input  logic        clk
    ,input  logic        resetn
    ,input  logic        req_valid
    ,output logic        req_ready
    ,input  mant_t       mant_a
    ,input  mant_t       mant_b
    ,input  sexp_t       exp_diff
    ,input  logic        sign
    ,input  special_t    special
    ,input  logic        nv
    ,input  logic        dz
    ,input  round_mode_t round_mode
    ,output logic        done_valid
    ,input  logic        done_ready
    ,output quot_t       quot
    ,output logic        sticky
    ,output sexp_t       d_exp
    ,output logic        d_sign
    ,output special_t    d_special
    ,output logic        d_nv
    ,output logic        d_dz
    ,output round_mode_t d_round_mode
);

    recur_state_t      state_q;
    logic [CNT_W-1:0]  cnt_q;
    // partial remainder stays below twice the divisor
    logic [FRAC_W+1:0] rem_q;
    mant_t             div_q;
    logic [FRAC_W+2:0] trial;
    logic              q_bit;
    logic              load;

    assign req_ready  = (state_q == RECUR_IDLE);
    assign done_valid = (state_q == RECUR_DONE);
    assign load       = req_valid & req_ready;

    // restoring step, a borrow means the divisor did not fit
    assign trial = {1'b0, rem_q} - {2'b00, div_q};
    assign q_bit = ~trial[FRAC_W+2];

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q <= RECUR_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                RECUR_IDLE: begin
                    if (req_valid) begin
                        state_q <= RECUR_BUSY;
                        cnt_q   <= CNT_W'(QUOT_BITS);
                    end
                end
                RECUR_BUSY: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == CNT_W'(1)) begin
                        state_q <= RECUR_DONE;
                    end
                end
                RECUR_DONE: begin
                    // hold until the round stage takes the result
                    if (done_ready) begin
                        state_q <= RECUR_IDLE;
                    end
                end
                default: state_q <= RECUR_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // datapath and side data
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            rem_q        <= {1'b0, mant_a};
            div_q        <= mant_b;
            d_exp        <= exp_diff;
            d_sign       <= sign;
            d_special    <= special;
            d_nv         <= nv;
            d_dz         <= dz;
            d_round_mode <= round_mode;
        end else if (state_q == RECUR_BUSY) begin
            quot  <= {quot[QUOT_BITS-2:0], q_bit};
            rem_q <= q_bit ? {trial[FRAC_W:0], 1'b0} : {rem_q[FRAC_W:0], 1'b0};
        end
    end

    // remainder is kept shifted, nonzero still means inexact
    assign sticky = |rem_q;

endmodule

// File: fdiv_unpack.sv
`timescale 1ns/1ns

module fdiv_unpack
    import fp16_pkg::*, fdiv_pkg::*;
(
     input  fp16_t    op_a
    ,input  fp16_t    op_b
    ,output mant_t    mant_a
    ,output mant_t    mant_b
    ,output sexp_t    exp_diff
    ,output logic     sign
    ,output special_t special
    ,output logic     nv
    ,output logic     dz
);

    // ----------------------------------------
    // operand classification
    // ----------------------------------------
    function automatic logic is_zero(input fp16_t op);
        return (op[FRAC_W +: EXP_W] == '0) && (op[FRAC_W-1:0] == '0);
    endfunction

    function automatic logic is_inf(input fp16_t op);
        return (&op[FRAC_W +: EXP_W]) && (op[FRAC_W-1:0] == '0);
    endfunction

    function automatic logic is_nan(input fp16_t op);
        return (&op[FRAC_W +: EXP_W]) && (op[FRAC_W-1:0] != '0);
    endfunction

    // signalling nan has the quiet bit clear
    function automatic logic is_snan(input fp16_t op);
        return is_nan(op) && !op[FRAC_W-1];
    endfunction

    // subnormals take exponent 1 without the hidden bit, then get
    // shifted up by their leading zero count
    function automatic void norm_op(input fp16_t op, output mant_t mant, output sexp_t exp);
        exp_field_t  e;
        frac_field_t f;
        mant_t       m;
        int          lz;
        int          base;
        e = op[FRAC_W +: EXP_W];
        f = op[FRAC_W-1:0];
        m = {(e != '0), f};
        lz = FRAC_W + 1;
        // scanning upward leaves the count of the highest set bit
        for (int i = 0; i <= FRAC_W; i++) begin
            if (m[i]) begin
                lz = FRAC_W - i;
            end
        end
        base = (e == '0) ? 1 : int'(e);
        mant = m << lz;
        exp = sexp_t'(base - EXP_BIAS - lz);
    endfunction

    sexp_t exp_a;
    sexp_t exp_b;

    always_comb begin
        norm_op(op_a, mant_a, exp_a);
        norm_op(op_b, mant_b, exp_b);
    end

    assign exp_diff = exp_a - exp_b;
    assign sign     = op_a[EXP_W+FRAC_W] ^ op_b[EXP_W+FRAC_W];

    // ----------------------------------------
    // special outcome
    // ----------------------------------------
    always_comb begin
        special = SPECIAL_NONE;
        nv = 1'b0;
        dz = 1'b0;
        if (is_nan(op_a) || is_nan(op_b) || (is_zero(op_a) && is_zero(op_b)) ||
            (is_inf(op_a) && is_inf(op_b))) begin
            special = SPECIAL_QNAN;
            nv = is_snan(op_a) | is_snan(op_b) | (is_zero(op_a) & is_zero(op_b)) |
                 (is_inf(op_a) & is_inf(op_b));
        end else if (is_inf(op_a)) begin
            special = SPECIAL_INF;
        end else if (is_zero(op_b)) begin
            // finite nonzero over zero
            special = SPECIAL_INF;
            dz = 1'b1;
        end else if (is_zero(op_a) || is_inf(op_b)) begin
            special = SPECIAL_ZERO;
        end
    end

endmodule

// File: fdiv_pkg.sv
package fdiv_pkg;

    // ----------------------------------------
    // recurrence sizing
    // ----------------------------------------
    // quotient bit weights run from 2^0 down to 2^-13
    localparam int QUOT_BITS = 14;
    localparam int CNT_W     = $clog2(QUOT_BITS + 1);

    // position of the round bit in the normalized quotient
    // 11 kept bits sit above it, the rest feeds sticky
    localparam int ROUND_POS = 2;

    typedef logic [QUOT_BITS-1:0] quot_t;

    // exception flags in nv dz of uf nx order
    typedef logic [4:0] flags_t;
    localparam int FLAG_NV = 4;
    localparam int FLAG_DZ = 3;
    localparam int FLAG_OF = 2;
    localparam int FLAG_UF = 1;
    localparam int FLAG_NX = 0;

    // only rtz truncates, every other code rounds to nearest even
    typedef logic [2:0] round_mode_t;
    localparam round_mode_t ROUND_RTZ = 3'b001;

    typedef enum logic [1:0] {
        SPECIAL_NONE,
        SPECIAL_QNAN,
        SPECIAL_INF,
        SPECIAL_ZERO
    } special_t;

    typedef enum logic [1:0] {
        RECUR_IDLE,
        RECUR_BUSY,
        RECUR_DONE
    } recur_state_t;

endpackage

// File: fp16_pkg.sv
package fp16_pkg;

    // ----------------------------------------
    // field widths
    // ----------------------------------------
    localparam int FRAC_W = 10;
    localparam int EXP_W  = 5;

    // bias and the largest biased exponent of a normal number
    localparam int EXP_BIAS     = 15;
    localparam int EXP_MAX_NORM = 30;

    // ----------------------------------------
    // format types
    // ----------------------------------------
    typedef logic [EXP_W+FRAC_W:0]  fp16_t;
    typedef logic [EXP_W-1:0]       exp_field_t;
    typedef logic [FRAC_W-1:0]      frac_field_t;

    // significand including the hidden bit
    typedef logic [FRAC_W:0]        mant_t;

    // unbiased working exponent
    // holds an exponent difference plus bias and rounding adjustments
    typedef logic signed [6:0]      sexp_t;

    // ----------------------------------------
    // special encodings
    // ----------------------------------------
    // canonical quiet nan is positive with the fraction msb set
    localparam fp16_t FP16_QNAN = 16'h7e00;

    // magnitudes only, the sign bit is added where they are used
    localparam logic [EXP_W+FRAC_W-1:0] FP16_INF_MAG = 15'h7c00;
    localparam logic [EXP_W+FRAC_W-1:0] FP16_MAX_MAG = 15'h7bff;

endpackage
